//--- source/cam_pkg.sv
// colour window applies to 8-bit channels after nibble repetition; blanking lengths are fixed
package cam_pkg;

  // rgb444 pixel as stored in the frame buffer, red in [11:8]
  typedef logic [11:0] pixel_t;

  // one display colour channel
  typedef logic [7:0] colour_t;

  // one-hot steering: [2] left, [1] centre, [0] right, zero for none
  typedef logic [2:0] dir_t;

  // orange window on expanded channels
  localparam colour_t ORANGE_R_MIN = 8'hC0;
  localparam colour_t ORANGE_G_MIN = 8'h40;
  localparam colour_t ORANGE_G_MAX = 8'hB0;
  localparam colour_t ORANGE_B_MAX = 8'h50;

  // marker painted over orange pixels (pure green)
  localparam colour_t MARKER_R = 8'd0;
  localparam colour_t MARKER_G = 8'd255;
  localparam colour_t MARKER_B = 8'd0;

  // horizontal blanking in display clocks
  localparam int unsigned H_FRONT = 8;
  localparam int unsigned H_SYNC  = 16;
  localparam int unsigned H_BACK  = 8;

  // vertical blanking in lines
  localparam int unsigned V_FRONT = 2;
  localparam int unsigned V_SYNC  = 2;
  localparam int unsigned V_BACK  = 2;

  // width of the reported orange pixel total
  localparam int unsigned COUNT_W = 18;

endpackage

//--- source/pixel_if.sv
// colour is expected to be zero whenever active is low; both syncs are active low
`timescale 1ns/1ps

interface pixel_if;
  import cam_pkg::*;

  // colour channels, 8 bits each
  colour_t red;
  colour_t green;
  colour_t blue;

  // display timing that travels with the colour
  logic    active;
  logic    hsync;
  logic    vsync;

  // producer of a timed stream
  modport source (
    output red, green, blue,
    output active, hsync, vsync
  );

  // consumer of a timed stream
  modport sink (
    input red, green, blue,
    input active, hsync, vsync
  );

endinterface

//--- source/ov7670_capture.sv
// expects RGB444 byte pairs with href framing each line; writes past the frame stay on the last address
`timescale 1ns/1ps

module ov7670_capture #(
  parameter int unsigned FRAME_W = 320,
  parameter int unsigned FRAME_H = 240
) (
  input  logic                                  ov7670_pclk,
  input  logic                                  rst_n,
  input  logic                                  vsync,
  input  logic                                  href,
  input  logic [7:0]                            d,
  output logic                                  wr_en,
  output logic [$clog2(FRAME_W*FRAME_H)-1:0]    wr_addr,
  output cam_pkg::pixel_t                       wr_data
);

  localparam int unsigned ADDR_W = $clog2(FRAME_W * FRAME_H);
  localparam int unsigned LAST   = FRAME_W * FRAME_H - 1;

  // high while waiting for the second byte of a pair
  logic       phase;
  // red nibble held from the first byte
  logic [3:0] red_nib;

  // control: byte phase, write strobe and address
  always_ff @(posedge ov7670_pclk or negedge rst_n) begin
    if (!rst_n) begin
      phase   <= 1'b0;
      wr_en   <= 1'b0;
      wr_addr <= '0;
    end else begin
      wr_en <= 1'b0;
      if (vsync) begin
        // new frame from the sensor
        phase   <= 1'b0;
        wr_addr <= '0;
      end else begin
        // step on after each write, hold at the last word
        if (wr_en && (wr_addr != ADDR_W'(LAST)))
          wr_addr <= wr_addr + 1'b1;
        if (href) begin
          phase <= ~phase;
          // second byte seen, write goes out next cycle
          if (phase)
            wr_en <= 1'b1;
        end
      end
    end
  end

  // payload: first byte red, second byte green and blue
  always_ff @(posedge ov7670_pclk) begin
    if (href && !phase)
      red_nib <= d[3:0];
    if (href && phase)
      wr_data <= {red_nib, d};
  end

  // every write lands inside the frame, also after the step that follows it
  addr_in_frame: assert property (@(posedge ov7670_pclk) disable iff (!rst_n)
    wr_en |=> (wr_addr <= ADDR_W'(LAST)));

endmodule

//--- source/frame_buffer.sv
// no reset on contents; a same-address read and write return the old word
`timescale 1ns/1ps

module frame_buffer #(
  parameter type         word_t = cam_pkg::pixel_t,
  parameter int unsigned DEPTH  = 76800
) (
  input  logic                     wr_clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  word_t                    wr_data,
  input  logic                     rd_clk,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output word_t                    rd_data
);

  // storage, maps onto block RAM
  word_t mem [DEPTH];

  // write port on the camera clock
  always_ff @(posedge wr_clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // registered read on the display clock, one cycle latency
  always_ff @(posedge rd_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- source/display_scan.sv
// display area equals the stored frame with no pixel doubling; output is one cycle after the counters
`timescale 1ns/1ps

module display_scan #(
  parameter int unsigned FRAME_W = 320,
  parameter int unsigned FRAME_H = 240
) (
  input  logic                               clk_25_vga,
  input  logic                               rst_n,
  output logic [$clog2(FRAME_W*FRAME_H)-1:0] rd_addr,
  input  cam_pkg::pixel_t                    rd_data,
  pixel_if.source                            px
);

  import cam_pkg::*;

  localparam int unsigned ADDR_W  = $clog2(FRAME_W * FRAME_H);
  localparam int unsigned LAST    = FRAME_W * FRAME_H - 1;
  localparam int unsigned H_TOTAL = FRAME_W + H_FRONT + H_SYNC + H_BACK;
  localparam int unsigned V_TOTAL = FRAME_H + V_FRONT + V_SYNC + V_BACK;
  localparam int unsigned HS_BEG  = FRAME_W + H_FRONT;
  localparam int unsigned VS_BEG  = FRAME_H + V_FRONT;

  logic [$clog2(H_TOTAL)-1:0] hcnt;
  logic [$clog2(V_TOTAL)-1:0] vcnt;
  logic [ADDR_W-1:0]          rd_cnt;
  logic                       active;
  logic                       hs_n;
  logic                       vs_n;
  logic                       line_end;
  logic                       frame_end;

  // timing decode, same cycle as the counters
  assign line_end  = (hcnt == H_TOTAL - 1);
  assign frame_end = line_end && (vcnt == V_TOTAL - 1);
  assign active    = (hcnt < FRAME_W) && (vcnt < FRAME_H);
  assign hs_n      = !((hcnt >= HS_BEG) && (hcnt < HS_BEG + H_SYNC));
  assign vs_n      = !((vcnt >= VS_BEG) && (vcnt < VS_BEG + V_SYNC));

  // address is presented with the counters, data comes back a cycle later
  assign rd_addr = rd_cnt;

  // pixel and line counters
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (line_end) begin
      hcnt <= '0;
      vcnt <= (vcnt == V_TOTAL - 1) ? '0 : vcnt + 1'b1;
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // linear read address, row * FRAME_W + column
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n)
      rd_cnt <= '0;
    else if (frame_end)
      rd_cnt <= '0;
    else if (active)
      // wrap after the last pixel so blanking never reads outside the frame
      rd_cnt <= (rd_cnt == ADDR_W'(LAST)) ? '0 : rd_cnt + 1'b1;
  end

  // timing delayed to match the RAM read
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      px.active <= 1'b0;
      px.hsync  <= 1'b1;
      px.vsync  <= 1'b1;
    end else begin
      px.active <= active;
      px.hsync  <= hs_n;
      px.vsync  <= vs_n;
    end
  end

  // 4 to 8 bits by nibble repetition, black outside the active area
  assign px.red   = px.active ? {rd_data[11:8], rd_data[11:8]} : '0;
  assign px.green = px.active ? {rd_data[7:4], rd_data[7:4]} : '0;
  assign px.blue  = px.active ? {rd_data[3:0], rd_data[3:0]} : '0;

endmodule

//--- source/target_finder.sv
// colour window is fixed in the package; adds one cycle to colour and timing alike
`timescale 1ns/1ps

module target_finder (
  input  logic    clk_25_vga,
  input  logic    rst_n,
  pixel_if.sink   in_px,
  pixel_if.source out_px,
  output logic    is_orange
);

  import cam_pkg::*;

  logic    hit;
  colour_t red_nx;
  colour_t green_nx;
  colour_t blue_nx;

  // window test, only active pixels count
  assign hit = in_px.active
            && (in_px.red >= ORANGE_R_MIN)
            && (in_px.green >= ORANGE_G_MIN)
            && (in_px.green <= ORANGE_G_MAX)
            && (in_px.blue <= ORANGE_B_MAX);

  // orange becomes the marker, the rest passes as is
  always_comb begin
    red_nx   = hit ? MARKER_R : in_px.red;
    green_nx = hit ? MARKER_G : in_px.green;
    blue_nx  = hit ? MARKER_B : in_px.blue;
  end

  // single register stage, strobe stays aligned with the colour
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      out_px.red    <= '0;
      out_px.green  <= '0;
      out_px.blue   <= '0;
      out_px.active <= 1'b0;
      out_px.hsync  <= 1'b1;
      out_px.vsync  <= 1'b1;
      is_orange     <= 1'b0;
    end else begin
      out_px.red    <= red_nx;
      out_px.green  <= green_nx;
      out_px.blue   <= blue_nx;
      out_px.active <= in_px.active;
      out_px.hsync  <= in_px.hsync;
      out_px.vsync  <= in_px.vsync;
      is_orange     <= hit;
    end
  end

endmodule

//--- source/classification.sv
// results change only at the vsync falling edge; ties resolve to centre, then left
`timescale 1ns/1ps

module classification #(
  parameter int unsigned FRAME_W   = 320,
  parameter int unsigned FRAME_H   = 240,
  parameter int unsigned MIN_COUNT = 64
) (
  input  logic                          clk_25_vga,
  input  logic                          rst_n,
  pixel_if.sink                         px,
  input  logic                          is_orange,
  output cam_pkg::dir_t                 direction,
  output logic                          orange_detected,
  output logic [cam_pkg::COUNT_W-1:0]   orange_count
);

  import cam_pkg::*;

  localparam int unsigned THIRD_W   = $clog2(FRAME_W * FRAME_H + 1);
  localparam int unsigned COL_W     = $clog2(FRAME_W + 1);
  localparam int unsigned COUNT_MAX = 2**COUNT_W - 1;

  logic [COL_W-1:0]   col;
  logic [THIRD_W-1:0] cnt_l;
  logic [THIRD_W-1:0] cnt_c;
  logic [THIRD_W-1:0] cnt_r;
  logic [THIRD_W+1:0] total;
  logic               vs_q;
  logic               frame_end;
  logic               detected;
  dir_t               dir_nx;

  // first clock of the sync pulse
  assign frame_end = vs_q && !px.vsync;
  assign total     = cnt_l + cnt_c + cnt_r;
  assign detected  = (total >= MIN_COUNT);

  // largest third wins, centre then left on a tie
  always_comb begin
    if (!detected)
      dir_nx = 3'b000;
    else if ((cnt_c >= cnt_l) && (cnt_c >= cnt_r))
      dir_nx = 3'b010;
    else if (cnt_l >= cnt_r)
      dir_nx = 3'b100;
    else
      dir_nx = 3'b001;
  end

  // column tracking and per-third accumulation
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      vs_q  <= 1'b1;
      col   <= '0;
      cnt_l <= '0;
      cnt_c <= '0;
      cnt_r <= '0;
    end else begin
      vs_q <= px.vsync;
      // column restarts in every blanking gap
      col  <= px.active ? col + 1'b1 : '0;
      if (frame_end) begin
        cnt_l <= '0;
        cnt_c <= '0;
        cnt_r <= '0;
      end else if (is_orange) begin
        if (col < FRAME_W / 3)
          cnt_l <= cnt_l + 1'b1;
        else if (col < 2 * FRAME_W / 3)
          cnt_c <= cnt_c + 1'b1;
        else
          cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  // frame results, held until the next frame end
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      direction       <= '0;
      orange_detected <= 1'b0;
      orange_count    <= '0;
    end else if (frame_end) begin
      direction       <= dir_nx;
      orange_detected <= detected;
      // saturate the total at the output width
      orange_count    <= (total > COUNT_MAX) ? '1 : COUNT_W'(total);
    end
  end

  // at most one steering bit
  dir_onehot: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
    $onehot0(direction));

  // the finder strobe must only come with an active pixel of the same cycle
  orange_in_active: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
    is_orange |-> px.active);

endmodule

//--- source/cam_top.sv
// PLL and camera setup are outside; one rst_n serves both clocks and is released with the camera idle
`timescale 1ns/1ps

module cam_top #(
  parameter int unsigned FRAME_W   = 320,
  parameter int unsigned FRAME_H   = 240,
  parameter int unsigned MIN_COUNT = 64
) (
  input  logic                        clk_25_vga,
  input  logic                        rst_n,
  input  logic                        ov7670_pclk,
  input  logic                        ov7670_vsync,
  input  logic                        ov7670_href,
  input  logic [7:0]                  ov7670_data,
  output logic                        vga_hsync,
  output logic                        vga_vsync,
  output logic                        vga_blank_n,
  output logic [7:0]                  vga_r,
  output logic [7:0]                  vga_g,
  output logic [7:0]                  vga_b,
  output logic                        orange_detected,
  output cam_pkg::dir_t               direction,
  output logic [cam_pkg::COUNT_W-1:0] orange_count
);

  import cam_pkg::*;

  localparam int unsigned ADDR_W = $clog2(FRAME_W * FRAME_H);

  // camera side write port
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  pixel_t            wr_data;
  // display side read port
  logic [ADDR_W-1:0] rd_addr;
  pixel_t            rd_data;
  logic              is_orange;

  // raw scan stream and marked stream
  pixel_if scan_px ();
  pixel_if mark_px ();

  ov7670_capture #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_capture (
    .ov7670_pclk(ov7670_pclk), .rst_n(rst_n), .vsync(ov7670_vsync),
    .href(ov7670_href), .d(ov7670_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data));

  frame_buffer #(.word_t(pixel_t), .DEPTH(FRAME_W * FRAME_H)) u_frame_buffer (
    .wr_clk(ov7670_pclk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_clk(clk_25_vga), .rd_addr(rd_addr), .rd_data(rd_data));

  display_scan #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_scan (
    .clk_25_vga(clk_25_vga), .rst_n(rst_n),
    .rd_addr(rd_addr), .rd_data(rd_data), .px(scan_px.source));

  target_finder u_finder (
    .clk_25_vga(clk_25_vga), .rst_n(rst_n),
    .in_px(scan_px.sink), .out_px(mark_px.source), .is_orange(is_orange));

  classification #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .MIN_COUNT(MIN_COUNT)) u_classifier (
    .clk_25_vga(clk_25_vga), .rst_n(rst_n), .px(mark_px.sink), .is_orange(is_orange),
    .direction(direction), .orange_detected(orange_detected),
    .orange_count(orange_count));

  // vga pins straight from the marked stream, two cycles after the counters
  assign vga_r       = mark_px.red;
  assign vga_g       = mark_px.green;
  assign vga_b       = mark_px.blue;
  assign vga_blank_n = mark_px.active;
  assign vga_hsync   = mark_px.hsync;
  assign vga_vsync   = mark_px.vsync;

endmodule

//--- verification/cam_checker.sv
// compares one displayed frame per request; assumes the request lands in the back porch before it
`timescale 1ns/1ps

module cam_checker #(
  parameter int FRAME_W    = 12,
  parameter int FRAME_H    = 6,
  parameter int MIN_COUNT  = 8,
  parameter int NUM_FRAMES = 7
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        vga_hsync,
  input  logic                        vga_vsync,
  input  logic                        vga_blank_n,
  input  logic [7:0]                  vga_r,
  input  logic [7:0]                  vga_g,
  input  logic [7:0]                  vga_b,
  input  logic                        orange_detected,
  input  cam_pkg::dir_t               direction,
  input  logic [cam_pkg::COUNT_W-1:0] orange_count,
  input  int                          frame_num,
  input  logic [11:0]                 bg_px,
  input  logic [11:0]                 rect_x0,
  input  logic [11:0]                 rect_y0,
  input  logic [11:0]                 rect_x1,
  input  logic [11:0]                 rect_y1,
  input  logic [11:0]                 rect_px,
  input  logic [11:0]                 gold_count,
  input  logic [11:0]                 gold_det,
  input  logic [11:0]                 gold_dir,
  output int                          frames_done,
  output int                          mismatches,
  output int                          failures
);

  // orange window on 8-bit channels and the marker colour
  localparam logic [7:0]  R_MIN   = 8'hC0;
  localparam logic [7:0]  G_MIN   = 8'h40;
  localparam logic [7:0]  G_MAX   = 8'hB0;
  localparam logic [7:0]  B_MAX   = 8'h50;
  localparam logic [23:0] MARKER  = 24'h00FF00;
  // hsync pulse length in display clocks
  localparam int          H_SYNC  = 16;
  localparam int          TIMEOUT = 2000;

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    mismatches++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    failures++;
  endtask

  // stored pixel at a frame position, rectangle corners inclusive
  function automatic logic [11:0] stored_px(input int row, input int col);
    if (col >= rect_x0 && col <= rect_x1 && row >= rect_y0 && row <= rect_y1)
      return rect_px;
    return bg_px;
  endfunction

  // nibble repetition to 24-bit rgb
  function automatic logic [23:0] expand(input logic [11:0] p);
    return {{2{p[11:8]}}, {2{p[7:4]}}, {2{p[3:0]}}};
  endfunction

  function automatic bit in_window(input logic [23:0] c);
    return c[23:16] >= R_MIN && c[15:8] >= G_MIN && c[15:8] <= G_MAX && c[7:0] <= B_MAX;
  endfunction

  // idle levels in reset, zero results right after it
  task automatic check_reset();
    int n;
    n = 0;
    @(posedge clk);
    if (rst_n !== 1'b0)
      report_failure("reset was not asserted at the start");
    @(negedge clk);
    if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || vga_blank_n !== 1'b0)
      report_mismatch("sync or blank level wrong during reset");
    while (rst_n !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (n >= TIMEOUT)
      report_failure("reset was never released");
    @(negedge clk);
    if (orange_count !== '0 || orange_detected !== 1'b0 || direction !== '0)
      report_mismatch("frame results not zero after reset");
  endtask

  task automatic check_frame(input int idx);
    int row;
    int col;
    int n;
    int hs_low;
    int cnt_l;
    int cnt_c;
    int cnt_r;
    int total;
    bit exp_det;
    logic [2:0] exp_dir;
    logic [23:0] exp_c;
    cnt_l = 0;
    cnt_c = 0;
    cnt_r = 0;
    // model of the frame results
    for (row = 0; row < FRAME_H; row++) begin
      for (col = 0; col < FRAME_W; col++) begin
        if (in_window(expand(stored_px(row, col)))) begin
          if (col < FRAME_W / 3)
            cnt_l++;
          else if (col < 2 * FRAME_W / 3)
            cnt_c++;
          else
            cnt_r++;
        end
      end
    end
    total   = cnt_l + cnt_c + cnt_r;
    exp_det = (total >= MIN_COUNT);
    if (!exp_det)
      exp_dir = 3'b000;
    else if (cnt_c >= cnt_l && cnt_c >= cnt_r)
      exp_dir = 3'b010;
    else if (cnt_l >= cnt_r)
      exp_dir = 3'b100;
    else
      exp_dir = 3'b001;
    if (gold_count != total || gold_det != 12'(exp_det) || gold_dir != 12'(exp_dir))
      report_failure($sformatf("golden line %0d disagrees with the frame rules", idx));
    // scan the displayed frame up to the next sync pulse
    row    = 0;
    col    = 0;
    n      = 0;
    hs_low = 0;
    @(negedge clk);
    while (vga_vsync !== 1'b0 && n < TIMEOUT) begin
      if (vga_blank_n === 1'b1) begin
        // gap before this line held one whole hsync pulse
        if (col == 0 && row > 0 && hs_low != H_SYNC)
          report_mismatch($sformatf("frame %0d line %0d hsync low for %0d clocks", idx, row,
            hs_low));
        if (vga_hsync !== 1'b1)
          report_mismatch($sformatf("frame %0d row %0d col %0d hsync low while active", idx,
            row, col));
        exp_c = expand(stored_px(row, col));
        if (in_window(exp_c))
          exp_c = MARKER;
        if ({vga_r, vga_g, vga_b} !== exp_c)
          report_mismatch($sformatf("frame %0d row %0d col %0d rgb %h expected %h",
            idx, row, col, {vga_r, vga_g, vga_b}, exp_c));
        col++;
      end else begin
        if ({vga_r, vga_g, vga_b} !== 24'h0)
          report_mismatch($sformatf("frame %0d colour %h in blanking", idx,
            {vga_r, vga_g, vga_b}));
        // a line just ended
        if (col != 0) begin
          if (col != FRAME_W)
            report_mismatch($sformatf("frame %0d line %0d has %0d active clocks", idx, row, col));
          row++;
          col    = 0;
          hs_low = 0;
        end
        if (vga_hsync === 1'b0)
          hs_low++;
      end
      n++;
      @(negedge clk);
    end
    if (n >= TIMEOUT)
      report_failure($sformatf("vga_vsync never fell during frame %0d", idx));
    if (row != FRAME_H)
      report_mismatch($sformatf("frame %0d has %0d active lines", idx, row));
    // results latch on the first clock with vsync low
    @(negedge clk);
    if (orange_count !== 18'(total))
      report_mismatch($sformatf("frame %0d orange_count %0d expected %0d", idx, orange_count, total));
    if (orange_detected !== exp_det)
      report_mismatch($sformatf("frame %0d orange_detected %b expected %b", idx,
        orange_detected, exp_det));
    if (direction !== exp_dir)
      report_mismatch($sformatf("frame %0d direction %b expected %b", idx, direction, exp_dir));
  endtask

  initial begin
    int n;
    frames_done = 0;
    mismatches  = 0;
    failures    = 0;
    check_reset();
    while (frames_done < NUM_FRAMES) begin
      n = 0;
      while (frame_num <= frames_done && n < TIMEOUT) begin
        @(posedge clk);
        n++;
      end
      if (n >= TIMEOUT)
        report_failure($sformatf("no stimulus arrived for frame %0d", frames_done));
      else
        check_frame(frames_done);
      frames_done++;
    end
  end

endmodule

//--- verification/tb_cam_top.sv
// golden file path is relative to the project root; frames are written only while the display blanks
`timescale 1ns/1ps

module tb_cam_top;

  localparam int FRAME_W      = 12;
  localparam int FRAME_H      = 6;
  localparam int MIN_COUNT    = 8;
  localparam int NUM_FRAMES   = 7;
  localparam int FIELDS       = 9;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT      = 2000;
  localparam logic [31:0] SEED = 32'h7a8e_386e;

  logic clk_25_vga;
  logic ov7670_pclk;
  logic rst_n;
  logic ov7670_vsync;
  logic ov7670_href;
  logic [7:0] ov7670_data;
  logic vga_hsync;
  logic vga_vsync;
  logic vga_blank_n;
  logic [7:0] vga_r;
  logic [7:0] vga_g;
  logic [7:0] vga_b;
  logic orange_detected;
  logic [2:0] direction;
  logic [17:0] orange_count;

  // whole golden table and the line of the frame now on show
  logic [11:0] golden [FIELDS*NUM_FRAMES];
  logic [11:0] cur [FIELDS];
  int frame_num;
  int frames_done;
  int mismatches;
  int failures;
  bit aborted;

  cam_top #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .MIN_COUNT(MIN_COUNT)) uut (
    .clk_25_vga(clk_25_vga), .rst_n(rst_n), .ov7670_pclk(ov7670_pclk),
    .ov7670_vsync(ov7670_vsync), .ov7670_href(ov7670_href), .ov7670_data(ov7670_data),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank_n(vga_blank_n),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .orange_detected(orange_detected),
    .direction(direction), .orange_count(orange_count));

  cam_checker #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .MIN_COUNT(MIN_COUNT),
    .NUM_FRAMES(NUM_FRAMES)) u_checker (
    .clk(clk_25_vga), .rst_n(rst_n), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync),
    .vga_blank_n(vga_blank_n), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
    .orange_detected(orange_detected), .direction(direction), .orange_count(orange_count),
    .frame_num(frame_num), .bg_px(cur[0]), .rect_x0(cur[1]), .rect_y0(cur[2]),
    .rect_x1(cur[3]), .rect_y1(cur[4]), .rect_px(cur[5]), .gold_count(cur[6]),
    .gold_det(cur[7]), .gold_dir(cur[8]), .frames_done(frames_done),
    .mismatches(mismatches), .failures(failures));

  // both clocks at 40 ns
  initial begin
    clk_25_vga = 1'b0;
    forever #20 clk_25_vga = ~clk_25_vga;
  end

  initial begin
    ov7670_pclk = 1'b0;
    forever #20 ov7670_pclk = ~ov7670_pclk;
  end

  // one camera clock of stimulus, changed on the falling edge
  task automatic drive_cam(input logic vs, input logic hr, input logic [7:0] d);
    @(negedge ov7670_pclk);
    ov7670_vsync = vs;
    ov7670_href  = hr;
    ov7670_data  = d;
  endtask

  // vsync pulse, then FRAME_H lines of byte pairs with a one clock gap
  task automatic write_frame(input int idx);
    int base;
    int row;
    int col;
    logic [11:0] p;
    base = idx * FIELDS;
    drive_cam(1'b1, 1'b0, 8'h00);
    drive_cam(1'b1, 1'b0, 8'h00);
    drive_cam(1'b0, 1'b0, 8'h00);
    for (row = 0; row < FRAME_H; row++) begin
      for (col = 0; col < FRAME_W; col++) begin
        if (col >= golden[base+1] && col <= golden[base+3] &&
            row >= golden[base+2] && row <= golden[base+4])
          p = golden[base+5];
        else
          p = golden[base];
        // upper nibble of the red byte is junk the capture must ignore
        drive_cam(1'b0, 1'b1, {4'($urandom_range(15, 0)), p[11:8]});
        drive_cam(1'b0, 1'b1, p[7:0]);
      end
      drive_cam(1'b0, 1'b0, 8'h00);
    end
  endtask

  // start of the next vga sync pulse, sampled between edges
  task automatic wait_vsync_fall(output bit ok);
    int n;
    n = 0;
    while (vga_vsync !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_25_vga);
      n++;
    end
    ok = (n < TIMEOUT);
    n = 0;
    while (ok && vga_vsync !== 1'b0 && n < TIMEOUT) begin
      @(negedge clk_25_vga);
      n++;
    end
    ok = ok && (n < TIMEOUT);
  endtask

  task automatic wait_checker(output bit ok);
    int n;
    n = 0;
    while (frames_done < NUM_FRAMES && n < TIMEOUT) begin
      @(posedge clk_25_vga);
      n++;
    end
    ok = (n < TIMEOUT);
    if (!ok)
      $display("timeout: checker finished %0d of %0d frames", frames_done, NUM_FRAMES);
  endtask

  task automatic finish_run();
    $display("summary: %0d mismatches, %0d other errors", mismatches, failures + int'(aborted));
    if (mismatches == 0 && failures == 0 && !aborted)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  initial begin
    bit ok;
    int f;
    int i;
    void'($urandom(SEED));
    rst_n        = 1'b0;
    ov7670_vsync = 1'b0;
    ov7670_href  = 1'b0;
    ov7670_data  = 8'h00;
    frame_num    = 0;
    aborted      = 1'b0;
    for (i = 0; i < FIELDS; i++)
      cur[i] = '0;
    $readmemh("verification/cam_golden.txt", golden);
    ok = !$isunknown(golden[FIELDS*NUM_FRAMES-1]);
    if (!ok)
      $display("golden file could not be read completely");
    repeat (RESET_CYCLES) @(negedge clk_25_vga);
    rst_n = 1'b1;
    for (f = 0; f < NUM_FRAMES && ok; f++) begin
      wait_vsync_fall(ok);
      if (!ok) begin
        $display("timeout: vga_vsync did not fall before frame %0d", f);
      end else begin
        write_frame(f);
        for (i = 0; i < FIELDS; i++)
          cur[i] = golden[f*FIELDS+i];
        // checker picks the frame up on its next rising edge
        frame_num = f + 1;
      end
    end
    if (ok)
      wait_checker(ok);
    aborted = !ok;
    finish_run();
  end

endmodule

//--- verification/cam_golden.txt
// columns (hex): background x0 y0 x1 y1 rectangle count detected direction
// rectangle corners inclusive; direction is one-hot left centre right
248 0 1 2 4 F80 00C 1 4
248 4 0 7 2 F80 00C 1 2
248 8 2 B 5 F80 010 1 1
248 0 2 7 3 F80 010 1 2
F80 4 0 7 5 248 030 1 4
000 9 0 B 1 E70 006 0 0
FC0 0 0 B 5 0F0 000 0 0

//--- vlog.f
source/cam_pkg.sv
source/pixel_if.sv
source/ov7670_capture.sv
source/frame_buffer.sv
source/display_scan.sv
source/target_finder.sv
source/classification.sv
source/cam_top.sv
verification/cam_checker.sv
verification/tb_cam_top.sv

//--- Bender.yml
package:
  name: cam_vision

sources:
  - files:
      - source/cam_pkg.sv
      - source/pixel_if.sv
      - source/ov7670_capture.sv
      - source/frame_buffer.sv
      - source/display_scan.sv
      - source/target_finder.sv
      - source/classification.sv
      - source/cam_top.sv
  - target: test
    files:
      - verification/cam_checker.sv
      - verification/tb_cam_top.sv
